//--- project.f
+incdir+verilog
verilog/mipsPkg.sv
verilog/instrDecoder.sv
verilog/cycleSequencer.sv
verilog/pcUnit.sv
verilog/regFile.sv
verilog/aluUnit.sv
verilog/mipsCore.sv
verification/mipsCore_checker.sv
verification/mipsCore_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run the mipsCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module mipsCore_tb -f project.f -o mipsCore_sim
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

./obj_dir/mipsCore_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "\*\*\* TEST PASSED \*\*\*" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- verification/mipsCore_checker.sv
`timescale 1ns/1ns
`include "mipsCore_macros.svh"

module mipsCore_checker (
	input logic                  clk,
	input logic                  rst,
	input logic                  memValid,
	input logic                  memReady,
	input logic                  memWrite,
	input logic [`MIPS_WORD-1:0] memAddr,
	input logic [`MIPS_WORD-1:0] memWdata,
	input logic                  regWrite,
	input mipsPkg::seqStateT     state
);

	int assertFails = 0;        // Read by the testbench report

	////////////////////////////////////////
	// Bus handshake rules
	////////////////////////////////////////
	// Request frozen until memReady, write data only matters on a write
	property heldWhileStalled;
		@(posedge clk) disable iff (rst)
		memValid && !memReady |=> memValid && $stable(memWrite) && $stable(memAddr)
			&& (!memWrite || $stable(memWdata));
	endproperty

	property idleInReset;
		@(posedge clk) rst |=> !memValid;
	endproperty

	property fetchAligned;
		@(posedge clk) disable iff (rst)
		memValid && (state == mipsPkg::stFetch) |-> (memAddr[1:0] == 2'b00);
	endproperty

	// Register file written in writeback, and writeback always writes
	property writeInWriteback;
		@(posedge clk) disable iff (rst)
		regWrite == (state == mipsPkg::stWriteback);
	endproperty

	stallHold: assert property (heldWhileStalled)
		else begin assertFails++; $error("Bus request changed while stalled"); end
	resetIdle: assert property (idleInReset)
		else begin assertFails++; $error("memValid high during reset"); end
	alignFetch: assert property (fetchAligned)
		else begin assertFails++; $error("Fetch address not word aligned"); end
	wbOnly: assert property (writeInWriteback)
		else begin assertFails++; $error("Register write does not match writeback"); end

endmodule

//--- verification/mipsCore_tb.sv
`timescale 1ns/1ns
`include "mipsCore_macros.svh"

module mipsCore_tb;

	localparam int CLK_PERIOD  = 40;
	localparam int DRIVE_DELAY = 2;            // Input skew after the rising edge
	localparam int WAIT_LIMIT  = 2000;         // Cycles allowed for any one wait
	localparam int NUM_STORES  = 10;
	localparam logic [31:0] LOOP_PC   = 32'h0000_005C;   // j to itself
	localparam logic [31:0] DATA_WORD = 32'h5A5A_C3C3;
	localparam logic [31:0] SEED      = 32'h2e79420e;

	// ISA encodings
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_J     = 6'h02;
	localparam logic [5:0] OP_JAL   = 6'h03;
	localparam logic [5:0] OP_BEQ   = 6'h04;
	localparam logic [5:0] OP_ORI   = 6'h0D;
	localparam logic [5:0] OP_LUI   = 6'h0F;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2B;
	localparam logic [5:0] FN_JR    = 6'h08;
	localparam logic [5:0] FN_ADD   = 6'h20;
	localparam logic [5:0] FN_SUB   = 6'h22;

	logic        clk, rst, memReady, memValid, memWrite;
	logic [31:0] memRdata, memAddr, memWdata;
	logic [31:0] mem [256];                    // 1 KB, word indexed
	logic [31:0] lfsr = SEED;
	logic [31:0] storeAddrQ[$], storeDataQ[$]; // Stores in bus order
	logic [31:0] expAddr [NUM_STORES], expData [NUM_STORES];
	string       testName [NUM_STORES];
	logic [31:0] firstAddr;
	logic        firstWrite;
	bit          firstSeen = 0, aborted = 0;
	int          loopFetches = 0, testCount = 0, failCount = 0;

	mipsCore dut_i (
		.clk(clk), .rst(rst), .memReady(memReady), .memRdata(memRdata),
		.memValid(memValid), .memWrite(memWrite), .memAddr(memAddr), .memWdata(memWdata)
	);

	bind mipsCore mipsCore_checker checker_i (
		.clk(clk), .rst(rst), .memValid(memValid), .memReady(memReady),
		.memWrite(memWrite), .memAddr(memAddr), .memWdata(memWdata),
		.regWrite(regWrite), .state(state)
	);

	////////////////////////////////////////
	// Encoding and ISA helpers
	////////////////////////////////////////
	function automatic logic [31:0] encR(input logic [4:0] rs, rt, rd, input logic [5:0] fn);
		return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs, rt,
			input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] encJ(input logic [5:0] op, input logic [31:0] addr);
		return {op, addr[27:2]};                // Word index of the target
	endfunction

	function automatic logic [31:0] zeroExt(input logic [15:0] v);
		return {16'h0000, v};
	endfunction

	function automatic logic [31:0] signExt(input logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	// Galois form, taps x^32+x^22+x^2+x+1
	function automatic logic [31:0] nextLfsr(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic loadMemory();
		logic [31:0] dataAddr;
		dataAddr = zeroExt(16'h0104) + signExt(16'hFFFC);     // lw base plus -4
		for (int i = 0; i < 256; i++)
			mem[i] = 32'hC0DE_0000 ^ (i * 4);                 // Address-dependent fill
		mem[0]  = encI(OP_ORI, 5'd0, 5'd1, 16'h1234);
		mem[1]  = encI(OP_LUI, 5'd0, 5'd2, 16'hABCD);
		mem[2]  = encI(OP_ORI, 5'd2, 5'd2, 16'h8001);         // Zero extension matters
		mem[3]  = encR(5'd1, 5'd2, 5'd3, FN_ADD);
		mem[4]  = encR(5'd1, 5'd2, 5'd4, FN_SUB);
		mem[5]  = encI(OP_ORI, 5'd0, 5'd6, 16'h0104);
		mem[6]  = encI(OP_SW, 5'd0, 5'd1, 16'h0300);
		mem[7]  = encI(OP_SW, 5'd0, 5'd2, 16'h0304);
		mem[8]  = encI(OP_SW, 5'd0, 5'd3, 16'h0308);
		mem[9]  = encI(OP_SW, 5'd0, 5'd4, 16'h030C);
		mem[10] = encI(OP_LW, 5'd6, 5'd5, 16'hFFFC);          // Negative offset
		mem[11] = encI(OP_SW, 5'd0, 5'd5, 16'h0310);
		mem[12] = encR(5'd1, 5'd2, 5'd0, FN_ADD);             // Write to r0
		mem[13] = encI(OP_SW, 5'd0, 5'd0, 16'h0314);
		mem[14] = encI(OP_BEQ, 5'd1, 5'd1, 16'h0001);         // Taken, skips 0x3C
		mem[15] = encI(OP_SW, 5'd0, 5'd1, 16'h0318);
		mem[16] = encI(OP_BEQ, 5'd1, 5'd2, 16'h0001);         // Not taken
		mem[17] = encI(OP_SW, 5'd0, 5'd2, 16'h031C);
		mem[18] = encJ(OP_JAL, 32'h0000_0064);
		mem[19] = encI(OP_SW, 5'd0, 5'd3, 16'h0324);          // Return point
		mem[20] = encJ(OP_J, 32'h0000_0058);
		mem[21] = encI(OP_SW, 5'd0, 5'd4, 16'h0328);          // Jumped over
		mem[22] = encI(OP_SW, 5'd0, 5'd1, 16'h032C);
		mem[23] = encJ(OP_J, LOOP_PC);
		mem[25] = encI(OP_SW, 5'd0, 5'd31, 16'h0320);         // Subroutine at 0x64
		mem[26] = encR(5'd31, 5'd0, 5'd0, FN_JR);
		mem[dataAddr[9:2]] = DATA_WORD;
	endtask

	task automatic setEntry(input int i, input string name, input logic [31:0] a, d);
		testName[i] = name;
		expAddr[i]  = a;
		expData[i]  = d;
	endtask

	// Expected stores from the ISA rules
	task automatic buildTable();
		logic [31:0] r1, r2, r3, r4;
		r1 = zeroExt(16'h1234);
		r2 = {16'hABCD, 16'h0000} | zeroExt(16'h8001);
		r3 = r1 + r2;
		r4 = r1 - r2;
		setEntry(0, "ori", 32'h300, r1);
		setEntry(1, "lui", 32'h304, r2);
		setEntry(2, "add", 32'h308, r3);
		setEntry(3, "sub", 32'h30C, r4);
		setEntry(4, "lw sw copy", 32'h310, DATA_WORD);
		setEntry(5, "r0 write", 32'h314, 32'h0);
		setEntry(6, "beq", 32'h31C, r2);                       // 0x318 must not appear
		setEntry(7, "jal link", 32'h320, 32'h48 + 32'd4);
		setEntry(8, "jr return", 32'h324, r3);
		setEntry(9, "j target", 32'h32C, r1);
	endtask

	task automatic checkValue(input string name, input logic [63:0] expected, actual);
		testCount++;
		assert (actual === expected)
			$display("PASS %s", name);
		else begin
			$display("FAIL %s expected %h actual %h", name, expected, actual);
			failCount++;
		end
	endtask

	task automatic waitStore(input string name);
		int n;
		n = 0;
		while (storeAddrQ.size() == 0 && n < WAIT_LIMIT) begin
			@(posedge clk);
			n++;
		end
		if (storeAddrQ.size() == 0) begin
			$display("Timeout: no store for test %s within %0d cycles", name, WAIT_LIMIT);
			failCount++;
			aborted = 1'b1;
		end
	endtask

	////////////////////////////////////////
	// Clock, memory model, bus monitor
	////////////////////////////////////////
	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		#DRIVE_DELAY;
		memReady = lfsr[0];                     // One LFSR bit per cycle
		lfsr     = nextLfsr(lfsr);
		memRdata = mem[memAddr[9:2]];           // Read data for the current request
	end

	// Mid-cycle view, the transfer lands on the next rising edge
	always @(negedge clk) begin
		if (!rst && memValid && memReady) begin
			if (!firstSeen) begin
				firstSeen  = 1'b1;
				firstAddr  = memAddr;
				firstWrite = memWrite;
			end
			if (memWrite) begin
				mem[memAddr[9:2]] = memWdata;
				storeAddrQ.push_back(memAddr);
				storeDataQ.push_back(memWdata);
			end else if (memAddr == LOOP_PC)
				loopFetches++;
		end
	end

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////
	initial begin
		int          n;
		logic [31:0] gotAddr, gotData;
		rst      = 1'b1;
		memReady = 1'b0;
		memRdata = '0;
		loadMemory();
		buildTable();
		repeat (5) @(posedge clk);
		#DRIVE_DELAY rst = 1'b0;

		for (n = 0; n < WAIT_LIMIT && !firstSeen; n++)
			@(posedge clk);
		if (!firstSeen) begin
			$display("Timeout: no memory transfer after reset");
			failCount++;
			aborted = 1'b1;
		end else
			checkValue("reset fetch", {`MIPS_RESET_PC, 32'h0}, {firstAddr, 31'h0, firstWrite});

		for (int i = 0; i < NUM_STORES && !aborted; i++) begin
			waitStore(testName[i]);
			if (!aborted) begin
				gotAddr = storeAddrQ.pop_front();
				gotData = storeDataQ.pop_front();
				checkValue(testName[i], {expAddr[i], expData[i]}, {gotAddr, gotData});
			end
		end

		// Core parked in its self-loop, nothing more may be stored
		if (!aborted) begin
			for (n = 0; n < WAIT_LIMIT && loopFetches < 4; n++)
				@(posedge clk);
			if (loopFetches < 4) begin
				$display("Timeout: core never settled in the final loop");
				failCount++;
			end else
				checkValue("no extra stores", 64'd0, 64'(storeAddrQ.size()));
		end

		$display("Tests run %0d, failed %0d, checker assertion failures %0d",
			testCount, failCount, dut_i.checker_i.assertFails);
		if (failCount == 0 && dut_i.checker_i.assertFails == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- verilog/aluUnit.sv
`timescale 1ns/1ns
`include "mipsCore_macros.svh"

module aluUnit (
	input  mipsPkg::aluOpT        aluOp,
	input  logic [`MIPS_WORD-1:0] a,
	input  logic [`MIPS_WORD-1:0] b,
	output logic [`MIPS_WORD-1:0] result,
	output logic                  equal
);

	always_comb begin
		case (aluOp)
			mipsPkg::aluAdd: result = a + b;            // Wraps, no overflow trap
			mipsPkg::aluSub: result = a - b;
			mipsPkg::aluOr:  result = a | b;
			mipsPkg::aluLui: begin
				// Low half of the immediate moves to the top
				result = {b[`MIPS_WORD/2-1:0], {(`MIPS_WORD/2){1'b0}}};
			end
			default:         result = b;
		endcase
	end

	// Compare for beq, independent of the operation
	assign equal = (a == b);

endmodule

//--- verilog/cycleSequencer.sv
`timescale 1ns/1ns

module cycleSequencer (
	input  logic              clk,
	input  logic              rst,
	input  logic              isLoad,
	input  logic              isStore,
	input  logic              writesReg,
	input  logic              memReady,
	output logic              memValid,
	output logic              memWrite,
	output logic              useDataAddr,
	output logic              irLoad,
	output logic              pcAdvance,
	output logic              aluLatch,
	output logic              mdrLoad,
	output logic              regWrite,
	output mipsPkg::seqStateT state
);

	mipsPkg::seqStateT nextState;
	logic              memDone;     // Handshake completes this edge

	assign memDone = memValid & memReady;

	////////////////////////////////////////
	// Next-state logic
	////////////////////////////////////////
	always_comb begin
		nextState = state;                                  // Hold while stalled
		case (state)
			mipsPkg::stFetch: begin
				if (memDone)
					nextState = mipsPkg::stDecode;
			end
			mipsPkg::stDecode: nextState = mipsPkg::stExecute;
			mipsPkg::stExecute: begin
				if (isLoad | isStore)
					nextState = mipsPkg::stMemory;
				else if (writesReg)
					nextState = mipsPkg::stWriteback;
				else
					nextState = mipsPkg::stFetch;           // beq, j, jr
			end
			mipsPkg::stMemory: begin
				if (memDone)
					nextState = isLoad ? mipsPkg::stWriteback : mipsPkg::stFetch;
			end
			default: nextState = mipsPkg::stFetch;          // Writeback and stray codes
		endcase
	end

	////////////////////////////////////////
	// State and bus request registers
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= mipsPkg::stFetch;
			memValid <= 1'b0;                               // Idle bus out of reset
			memWrite <= 1'b0;
		end else begin
			state    <= nextState;
			// Request follows the state it enters, so it holds across a stall
			memValid <= (nextState == mipsPkg::stFetch) || (nextState == mipsPkg::stMemory);
			memWrite <= (nextState == mipsPkg::stMemory) && isStore;
		end
	end

	// Single-cycle enables
	assign useDataAddr = (state == mipsPkg::stMemory);     // Address from ALU latch
	assign irLoad      = (state == mipsPkg::stFetch) && memDone;
	assign pcAdvance   = (state == mipsPkg::stExecute);
	assign aluLatch    = (state == mipsPkg::stExecute);
	assign mdrLoad     = useDataAddr && memDone && isLoad;  // Read data valid with ready
	assign regWrite    = (state == mipsPkg::stWriteback) && writesReg;

endmodule

//--- verilog/instrDecoder.sv
`timescale 1ns/1ns

module instrDecoder (
	input  mipsPkg::opcodeT  opcode,
	input  mipsPkg::functT   funct,
	output mipsPkg::destSelT destSel,
	output logic             writesReg,
	output logic             signExtend,
	output logic             aluSrcImm,
	output mipsPkg::aluOpT   aluOp,
	output mipsPkg::npcSelT  npcSel,
	output logic             isLoad,
	output logic             isStore,
	output logic             isBranch,
	output mipsPkg::wbSrcT   wbSrc
);

	////////////////////////////////////////
	// Instruction match terms
	////////////////////////////////////////
	logic insRtype;
	logic insAdd, insSub, insJr;
	logic insOri, insLui, insLw, insSw;
	logic insBeq, insJ, insJal;

	assign insRtype = (opcode == mipsPkg::opRtype);
	assign insAdd   = insRtype & (funct == mipsPkg::fnAdd);
	assign insSub   = insRtype & (funct == mipsPkg::fnSub);
	assign insJr    = insRtype & (funct == mipsPkg::fnJr);
	assign insOri   = (opcode == mipsPkg::opOri);
	assign insLui   = (opcode == mipsPkg::opLui);
	assign insLw    = (opcode == mipsPkg::opLw);
	assign insSw    = (opcode == mipsPkg::opSw);
	assign insBeq   = (opcode == mipsPkg::opBeq);
	assign insJ     = (opcode == mipsPkg::opJ);
	assign insJal   = (opcode == mipsPkg::opJal);

	////////////////////////////////////////
	// Control bundle
	////////////////////////////////////////
	assign writesReg  = insAdd | insSub | insOri | insLui | insLw | insJal;
	assign signExtend = insLw | insSw | insBeq;     // Ori and lui take zero extension
	assign aluSrcImm  = insOri | insLui | insLw | insSw;
	assign isLoad     = insLw;
	assign isStore    = insSw;
	assign isBranch   = insBeq;                     // Qualifies the equal flag

	always_comb begin
		destSel = mipsPkg::destRt;                  // I-type default
		if (insAdd | insSub)
			destSel = mipsPkg::destRd;
		else if (insJal)
			destSel = mipsPkg::destRa;              // Link into r31
	end

	always_comb begin
		aluOp = mipsPkg::aluPassB;                  // Jumps and unknown codes
		if (insAdd | insLw | insSw)
			aluOp = mipsPkg::aluAdd;                // Address is base plus offset
		else if (insSub | insBeq)
			aluOp = mipsPkg::aluSub;
		else if (insOri)
			aluOp = mipsPkg::aluOr;
		else if (insLui)
			aluOp = mipsPkg::aluLui;
	end

	always_comb begin
		npcSel = mipsPkg::npcSeq;                   // No-op flow for unknowns
		if (insBeq)
			npcSel = mipsPkg::npcBranch;
		else if (insJ | insJal)
			npcSel = mipsPkg::npcJump;
		else if (insJr)
			npcSel = mipsPkg::npcReg;
	end

	always_comb begin
		wbSrc = mipsPkg::wbAlu;
		if (insLw)
			wbSrc = mipsPkg::wbMem;
		else if (insJal)
			wbSrc = mipsPkg::wbLink;
	end

endmodule

//--- verilog/mipsCore.sv
`timescale 1ns/1ns
`include "mipsCore_macros.svh"

module mipsCore (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  memReady,
	input  logic [`MIPS_WORD-1:0] memRdata,
	output logic                  memValid,
	output logic                  memWrite,
	output logic [`MIPS_WORD-1:0] memAddr,
	output logic [`MIPS_WORD-1:0] memWdata
);

	////////////////////////////////////////
	// Latches and internal nets
	////////////////////////////////////////
	logic [`MIPS_WORD-1:0] ir;          // Instruction register
	logic [`MIPS_WORD-1:0] opA, opB;    // Operands read in decode
	logic [`MIPS_WORD-1:0] aluOut;
	logic [`MIPS_WORD-1:0] linkAddr;    // pc+4 before jal redirects
	logic [`MIPS_WORD-1:0] mdr;         // Load data

	mipsPkg::opcodeT   opcode;
	mipsPkg::functT    funct;
	mipsPkg::destSelT  destSel;
	mipsPkg::aluOpT    aluOp;
	mipsPkg::npcSelT   npcSel;
	mipsPkg::wbSrcT    wbSrc;
	mipsPkg::seqStateT state;
	logic writesReg, signExtend, aluSrcImm, isLoad, isStore, isBranch;
	logic useDataAddr, irLoad, pcAdvance, aluLatch, mdrLoad, regWrite;

	logic [`MIPS_WORD-1:0]         pc, pcPlus4, rsData, rtData;
	logic [`MIPS_WORD-1:0]         immExt, aluB, aluResult, wbData;
	logic [15:0]                   imm;
	logic [$clog2(`MIPS_REGS)-1:0] destAddr;
	logic                          aluEqual;

	assign opcode = mipsPkg::opcodeT'(ir[`OPCODE_MSB:`OPCODE_LSB]);
	assign funct  = mipsPkg::functT'(ir[`FUNCT]);
	assign imm    = ir[`IMM];

	instrDecoder decoder_i (
		.opcode(opcode), .funct(funct), .destSel(destSel), .writesReg(writesReg),
		.signExtend(signExtend), .aluSrcImm(aluSrcImm), .aluOp(aluOp), .npcSel(npcSel),
		.isLoad(isLoad), .isStore(isStore), .isBranch(isBranch), .wbSrc(wbSrc)
	);

	cycleSequencer sequencer_i (
		.clk(clk), .rst(rst), .isLoad(isLoad), .isStore(isStore), .writesReg(writesReg),
		.memReady(memReady), .memValid(memValid), .memWrite(memWrite),
		.useDataAddr(useDataAddr), .irLoad(irLoad), .pcAdvance(pcAdvance),
		.aluLatch(aluLatch), .mdrLoad(mdrLoad), .regWrite(regWrite), .state(state)
	);

	pcUnit pc_i (
		.clk(clk), .rst(rst), .pcAdvance(pcAdvance), .npcSel(npcSel),
		.branchTaken(isBranch & aluEqual), .immOffset(imm), .jumpTarget(ir[`TARGET]),
		.regTarget(opA), .pc(pc), .pcPlus4(pcPlus4)
	);

	regFile regs_i (
		.clk(clk), .rst(rst), .rs(ir[`RS]), .rt(ir[`RT]), .writeAddr(destAddr),
		.writeData(wbData), .regWrite(regWrite), .rsData(rsData), .rtData(rtData)
	);

	aluUnit alu_i (.aluOp(aluOp), .a(opA), .b(aluB), .result(aluResult), .equal(aluEqual));

	////////////////////////////////////////
	// Datapath registers
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (irLoad)
			ir <= memRdata;
		if (state == mipsPkg::stDecode) begin
			opA <= rsData;
			opB <= rtData;                  // Store data too
		end
		if (aluLatch) begin
			aluOut   <= aluResult;
			linkAddr <= pcPlus4;            // pc still points at this instruction
		end
		if (mdrLoad)
			mdr <= memRdata;
	end

	// Immediate and ALU source
	assign immExt = signExtend ? {{(`MIPS_WORD-16){imm[15]}}, imm} : {{(`MIPS_WORD-16){1'b0}}, imm};
	assign aluB   = aluSrcImm ? immExt : opB;

	always_comb begin
		case (destSel)
			mipsPkg::destRd: destAddr = ir[`RD];
			mipsPkg::destRa: destAddr = '1;     // r31
			default:         destAddr = ir[`RT];
		endcase
		case (wbSrc)
			mipsPkg::wbMem:  wbData = mdr;
			mipsPkg::wbLink: wbData = linkAddr;
			default:         wbData = aluOut;
		endcase
	end

	// Shared bus, fetch from pc, data from the ALU latch
	assign memAddr  = useDataAddr ? aluOut : pc;
	assign memWdata = opB;

endmodule

//--- verilog/mipsCore_macros.svh
`ifndef MIPSCORE_MACROS_SVH
`define MIPSCORE_MACROS_SVH

////////////////////////////////////////
// Datapath sizing
////////////////////////////////////////
`define MIPS_WORD      32
`define MIPS_REGS      32
`define MIPS_RESET_PC  32'h0000_0000    // First fetch address

////////////////////////////////////////
// Instruction field positions
////////////////////////////////////////
`define OPCODE_MSB     31
`define OPCODE_LSB     26
`define RS             25:21
`define RT             20:16
`define RD             15:11            // R-type destination
`define FUNCT          5:0
`define IMM            15:0             // I-type immediate
`define TARGET         25:0             // J-type word index

`endif

//--- verilog/mipsPkg.sv
package mipsPkg;

	// Primary opcode field, bits 31:26
	typedef enum logic [5:0] {
		opRtype = 6'b000000,    // Funct selects the operation
		opJ     = 6'b000010,
		opJal   = 6'b000011,
		opBeq   = 6'b000100,
		opOri   = 6'b001101,
		opLui   = 6'b001111,
		opLw    = 6'b100011,
		opSw    = 6'b101011
	} opcodeT;

	// R-type funct field, bits 5:0
	typedef enum logic [5:0] {
		fnJr  = 6'b001000,
		fnAdd = 6'b100000,
		fnSub = 6'b100010
	} functT;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluOr,
		aluLui,     // Immediate into upper half
		aluPassB    // Result unused by the instruction
	} aluOpT;

	typedef enum logic [1:0] {npcSeq, npcBranch, npcJump, npcReg} npcSelT;

	typedef enum logic [1:0] {wbAlu, wbMem, wbLink} wbSrcT;

	typedef enum logic [1:0] {destRt, destRd, destRa} destSelT;

	// Multi-cycle steps of one instruction
	typedef enum logic [2:0] {
		stFetch, stDecode, stExecute, stMemory, stWriteback
	} seqStateT;

endpackage

//--- verilog/pcUnit.sv
`timescale 1ns/1ns
`include "mipsCore_macros.svh"

module pcUnit (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  pcAdvance,
	input  mipsPkg::npcSelT       npcSel,
	input  logic                  branchTaken,
	input  logic [15:0]           immOffset,
	input  logic [25:0]           jumpTarget,
	input  logic [`MIPS_WORD-1:0] regTarget,
	output logic [`MIPS_WORD-1:0] pc,
	output logic [`MIPS_WORD-1:0] pcPlus4
);

	logic [`MIPS_WORD-1:0] branchAddr;
	logic [`MIPS_WORD-1:0] jumpAddr;
	logic [`MIPS_WORD-1:0] nextPc;

	assign pcPlus4 = pc + `MIPS_WORD'd4;    // Also the jal link value

	// Word offset, sign extended, relative to the delay slot address
	assign branchAddr = pcPlus4 + {{(`MIPS_WORD-18){immOffset[15]}}, immOffset, 2'b00};
	assign jumpAddr   = {pcPlus4[`MIPS_WORD-1:28], jumpTarget, 2'b00};   // Same 256 MB region

	always_comb begin
		case (npcSel)
			mipsPkg::npcBranch: nextPc = branchTaken ? branchAddr : pcPlus4;
			mipsPkg::npcJump:   nextPc = jumpAddr;
			mipsPkg::npcReg:    nextPc = regTarget;     // jr
			default:            nextPc = pcPlus4;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			pc <= `MIPS_RESET_PC;
		else if (pcAdvance)
			pc <= nextPc;                           // Once per instruction, in execute
	end

endmodule

//--- verilog/regFile.sv
`timescale 1ns/1ns
`include "mipsCore_macros.svh"

module regFile (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [$clog2(`MIPS_REGS)-1:0] rs,
	input  logic [$clog2(`MIPS_REGS)-1:0] rt,
	input  logic [$clog2(`MIPS_REGS)-1:0] writeAddr,
	input  logic [`MIPS_WORD-1:0]         writeData,
	input  logic                          regWrite,
	output logic [`MIPS_WORD-1:0]         rsData,
	output logic [`MIPS_WORD-1:0]         rtData
);

	logic [`MIPS_WORD-1:0] regs [`MIPS_REGS];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `MIPS_REGS; i++)
				regs[i] <= '0;
		end else if (regWrite && (writeAddr != '0)) begin
			regs[writeAddr] <= writeData;       // r0 never written, stays zero
		end
	end

	// Combinational read ports
	assign rsData = regs[rs];
	assign rtData = regs[rt];

endmodule
